// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := core_trace_tb
FILELIST  := core_trace.f

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir

// ==== capture_fsm.sv ====
`timescale 1ns/1ps

module capture_fsm (
    input logic clk,
    input logic rst,
    input logic start,
    input core_trace_pkg::count_t retired_count,
    input core_trace_pkg::count_t window_len,
    output logic clear,
    output logic capturing,
    output logic done
);

    core_trace_pkg::capture_state_e state;
    core_trace_pkg::capture_state_e state_next;
    logic window_full;

    assign window_full = (retired_count == window_len);

    always_comb begin
        state_next = state;
        unique case (state)
            core_trace_pkg::IDLE: begin
                if (start) state_next = core_trace_pkg::CAPTURE;
            end
            core_trace_pkg::CAPTURE: begin
                // start again restarts the window
                if (start) begin
                    state_next = core_trace_pkg::CAPTURE;
                end else if (window_full) begin
                    state_next = core_trace_pkg::DONE;
                end
            end
            core_trace_pkg::DONE: begin
                if (start) state_next = core_trace_pkg::CAPTURE;
            end
            default: state_next = core_trace_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= core_trace_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign clear = start;
    // window closes on hitting the limit one cycle before DONE
    assign capturing = (state == core_trace_pkg::CAPTURE) && !window_full;
    assign done = (state == core_trace_pkg::DONE);

endmodule

// ==== core_trace.f ====
core_trace_pkg.sv
inst_classifier.sv
stage_tracker.sv
trace_counters.sv
capture_fsm.sv
core_trace.sv
core_trace_tb.sv

// ==== core_trace.sv ====
`timescale 1ns/1ps

module core_trace (
    input logic clk,
    input logic rst,
    input core_trace_pkg::exe_req_t exe,
    input logic stall,
    input logic retired,
    input logic start,
    input core_trace_pkg::count_t window_len,
    output core_trace_pkg::retire_rec_t retire_rec,
    output logic trace_valid,
    output core_trace_pkg::counts_t counts,
    output logic done
);

    core_trace_pkg::stage_rec_t wbk_rec;
    core_trace_pkg::inst_fmt_e wbk_fmt;
    logic wbk_nop;
    logic clear;
    logic capturing;

    stage_tracker u_stage_tracker (
        .clk(clk),
        .rst(rst),
        .exe(exe),
        .stall(stall),
        .wbk_rec(wbk_rec)
    );

    inst_classifier u_inst_classifier (
        .inst(wbk_rec.inst),
        .fmt(wbk_fmt),
        .is_nop(wbk_nop)
    );

    // inst and pc only show up on a retiring cycle
    always_comb begin
        retire_rec.stage = wbk_rec;
        retire_rec.stage.inst = retired ? wbk_rec.inst : '0;
        retire_rec.stage.pc = retired ? wbk_rec.pc : '0;
        retire_rec.fmt = wbk_fmt;
        retire_rec.is_nop = wbk_nop;
    end

    assign trace_valid = retired && capturing;

    trace_counters u_trace_counters (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .count_en(trace_valid),
        .rec(retire_rec),
        .counts(counts)
    );

    capture_fsm u_capture_fsm (
        .clk(clk),
        .rst(rst),
        .start(start),
        .retired_count(counts.retired),
        .window_len(window_len),
        .clear(clear),
        .capturing(capturing),
        .done(done)
    );

endmodule

// ==== core_trace_pkg.sv ====
package core_trace_pkg;

    // basic widths
    localparam int unsigned INST_WIDTH = 32;
    localparam int unsigned ARCH_WIDTH = 32;
    localparam int unsigned COUNT_WIDTH = 16;
    localparam int unsigned SIZE_WIDTH = 4;
    localparam int unsigned OPC7_WIDTH = 7;

    typedef logic [INST_WIDTH-1:0] inst_width_t;
    typedef logic [ARCH_WIDTH-1:0] arch_width_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [SIZE_WIDTH-1:0] size_code_t;
    typedef logic [1:0] dmem_width_t;
    typedef logic [OPC7_WIDTH-1:0] opc7_t;

    // bit 2 of a size code flags a store and bits 1:0 give the width
    localparam int unsigned SIZE_STORE_BIT = 2;
    localparam size_code_t DMEM_SIZE_NA = 4'd8;

    // counters stop at all ones
    localparam count_t COUNT_MAX = '1;

    // addi x0, x0, 0
    localparam inst_width_t NOP_INST = 32'h0000_0013;

    // base opcodes
    localparam opc7_t OPC7_R_TYPE = 7'b011_0011;
    localparam opc7_t OPC7_I_TYPE = 7'b001_0011;
    localparam opc7_t OPC7_LOAD = 7'b000_0011;
    localparam opc7_t OPC7_JALR = 7'b110_0111;
    localparam opc7_t OPC7_SYSTEM = 7'b111_0011;
    localparam opc7_t OPC7_STORE = 7'b010_0011;
    localparam opc7_t OPC7_BRANCH = 7'b110_0011;
    localparam opc7_t OPC7_JAL = 7'b110_1111;
    localparam opc7_t OPC7_LUI = 7'b011_0111;
    localparam opc7_t OPC7_AUIPC = 7'b001_0111;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_J,
        FMT_U,
        FMT_NONE
    } inst_fmt_e;

    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        DONE
    } capture_state_e;

    // per-stage side-band of 102 bits
    typedef struct packed {
        inst_width_t inst;
        arch_width_t pc;
        logic branch_inst;
        logic branch_taken;
        arch_width_t dmem_addr;
        size_code_t dmem_size;
    } stage_rec_t;

    // raw execute-stage view from the core
    typedef struct packed {
        inst_width_t inst;
        arch_width_t pc;
        logic branch_inst;
        logic branch_taken;
        logic dmem_valid;
        arch_width_t dmem_addr;
        logic dmem_store;
        dmem_width_t dmem_width;
    } exe_req_t;

    typedef struct packed {
        stage_rec_t stage;
        inst_fmt_e fmt;
        logic is_nop;
    } retire_rec_t;

    typedef struct packed {
        count_t retired;
        count_t branches;
        count_t taken;
        count_t loads;
        count_t stores;
    } counts_t;

endpackage

// ==== core_trace_tb.sv ====
`timescale 1ns/1ps

module core_trace_tb;

    localparam int NUM_CYCLES = 600;
    localparam int CLK_PERIOD = 8;

    // empty pipeline slot as seen at writeback
    localparam core_trace_pkg::stage_rec_t EMPTY_SLOT = '{
        inst: '0,
        pc: '0,
        branch_inst: 1'b0,
        branch_taken: 1'b0,
        dmem_addr: '0,
        dmem_size: core_trace_pkg::DMEM_SIZE_NA
    };

    logic clk;
    logic rst;
    core_trace_pkg::exe_req_t exe;
    logic stall;
    logic retired;
    logic start;
    core_trace_pkg::count_t window_len;
    core_trace_pkg::retire_rec_t retire_rec;
    logic trace_valid;
    core_trace_pkg::counts_t counts;
    logic done;

    // reference model state
    core_trace_pkg::stage_rec_t m_mem;
    core_trace_pkg::stage_rec_t m_wbk;
    core_trace_pkg::capture_state_e m_state;
    core_trace_pkg::counts_t m_counts;

    logic [31:0] rng;
    logic [31:0] pc_next;
    logic [6:0] opc_table [10];
    int errors;

    core_trace UUT (
        .clk(clk),
        .rst(rst),
        .exe(exe),
        .stall(stall),
        .retired(retired),
        .start(start),
        .window_len(window_len),
        .retire_rec(retire_rec),
        .trace_valid(trace_valid),
        .counts(counts),
        .done(done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // encoding format straight from the opcode table
    function automatic core_trace_pkg::inst_fmt_e fmt_of(input logic [31:0] word);
        case (word[6:0])
            7'b011_0011: return core_trace_pkg::FMT_R;
            7'b001_0011, 7'b000_0011, 7'b110_0111, 7'b111_0011: return core_trace_pkg::FMT_I;
            7'b010_0011: return core_trace_pkg::FMT_S;
            7'b110_0011: return core_trace_pkg::FMT_B;
            7'b110_1111: return core_trace_pkg::FMT_J;
            7'b011_0111, 7'b001_0111: return core_trace_pkg::FMT_U;
            default: return core_trace_pkg::FMT_NONE;
        endcase
    endfunction

    function automatic core_trace_pkg::stage_rec_t to_stage_rec(
        input core_trace_pkg::exe_req_t e
    );
        core_trace_pkg::stage_rec_t r;
        r = EMPTY_SLOT;
        r.inst = e.inst;
        r.pc = e.pc;
        r.branch_inst = e.branch_inst;
        r.branch_taken = e.branch_inst & e.branch_taken;
        if (e.dmem_valid) begin
            r.dmem_addr = e.dmem_addr;
            // bit 2 store, bits 1:0 width
            r.dmem_size = {2'b00, e.dmem_width} | (e.dmem_store ? 4'd4 : 4'd0);
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // one clock edge of the model from pre-edge values
    task automatic step_model();
        logic full;
        logic count_en;
        logic has_access;
        full = (m_counts.retired == window_len);
        count_en = retired && (m_state == core_trace_pkg::CAPTURE) && !full;
        has_access = (m_wbk.dmem_size != core_trace_pkg::DMEM_SIZE_NA);
        if (start) begin
            m_counts = '0;
        end else if (count_en) begin
            m_counts.retired = m_counts.retired + 16'd1;
            m_counts.branches = m_counts.branches + 16'(m_wbk.branch_inst);
            m_counts.taken = m_counts.taken + 16'(m_wbk.branch_taken);
            m_counts.loads = m_counts.loads + 16'(has_access && !m_wbk.dmem_size[2]);
            m_counts.stores = m_counts.stores + 16'(has_access && m_wbk.dmem_size[2]);
        end
        if (start) begin
            m_state = core_trace_pkg::CAPTURE;
        end else if (m_state == core_trace_pkg::CAPTURE && full) begin
            m_state = core_trace_pkg::DONE;
        end
        // writeback goes first as it reads the old mem slot
        if (stall || m_mem.inst == '0) begin
            m_wbk = EMPTY_SLOT;
        end else begin
            m_wbk = m_mem;
        end
        if (!stall) begin
            m_mem = (exe.inst == '0) ? EMPTY_SLOT : to_stage_rec(exe);
        end
    endtask

    task automatic drive_inputs(input int cyc);
        logic [3:0] pick;
        logic [31:0] r;
        rng = next_rand(rng);
        pick = 4'(rng % 32'd12);
        rng = next_rand(rng);
        r = rng;
        if (pick < 4'd10) begin
            exe.inst = {r[31:7], opc_table[pick]};
        end else if (pick == 4'd10) begin
            exe.inst = core_trace_pkg::NOP_INST;
        end else begin
            exe.inst = '0;
        end
        exe.pc = pc_next;
        pc_next = pc_next + 32'd4;
        exe.branch_inst = (pick == 4'd6);
        // random taken and store on other words exercise the masking
        exe.branch_taken = r[0];
        exe.dmem_valid = (pick == 4'd2) || (pick == 4'd5);
        exe.dmem_store = (pick == 4'd5) || (pick != 4'd2 && r[1]);
        exe.dmem_width = r[3:2] % 2'd3;
        rng = next_rand(rng);
        exe.dmem_addr = rng;
        rng = next_rand(rng);
        stall = (rng % 32'd5) == 32'd0;
        rng = next_rand(rng);
        retired = (m_wbk.inst != '0) && ((rng % 32'd10) != 32'd0);
        start = (cyc % 120 == 5) || (cyc == 40);
        if (start) begin
            rng = next_rand(rng);
            window_len = 16'd16 + 16'(rng % 32'd32);
        end
    endtask

    task automatic check_outputs();
        logic [31:0] exp_inst;
        logic [31:0] exp_pc;
        logic exp_valid;
        logic exp_nop;
        exp_inst = retired ? m_wbk.inst : '0;
        exp_pc = retired ? m_wbk.pc : '0;
        exp_valid = retired && (m_state == core_trace_pkg::CAPTURE)
                    && (m_counts.retired != window_len);
        exp_nop = (m_wbk.inst == 32'h0000_0013);
        if (retire_rec.stage.inst !== exp_inst) begin
            report_mismatch("retire_rec.inst", retire_rec.stage.inst, exp_inst);
        end
        if (retire_rec.stage.pc !== exp_pc) begin
            report_mismatch("retire_rec.pc", retire_rec.stage.pc, exp_pc);
        end
        if (retire_rec.stage.branch_inst !== m_wbk.branch_inst) begin
            report_mismatch("branch_inst", 32'(retire_rec.stage.branch_inst),
                            32'(m_wbk.branch_inst));
        end
        if (retire_rec.stage.branch_taken !== m_wbk.branch_taken) begin
            report_mismatch("branch_taken", 32'(retire_rec.stage.branch_taken),
                            32'(m_wbk.branch_taken));
        end
        if (retire_rec.stage.dmem_addr !== m_wbk.dmem_addr) begin
            report_mismatch("dmem_addr", retire_rec.stage.dmem_addr, m_wbk.dmem_addr);
        end
        if (retire_rec.stage.dmem_size !== m_wbk.dmem_size) begin
            report_mismatch("dmem_size", 32'(retire_rec.stage.dmem_size),
                            32'(m_wbk.dmem_size));
        end
        if (retire_rec.fmt !== fmt_of(m_wbk.inst)) begin
            report_mismatch("fmt", 32'(retire_rec.fmt), 32'(fmt_of(m_wbk.inst)));
        end
        if (retire_rec.is_nop !== exp_nop) begin
            report_mismatch("is_nop", 32'(retire_rec.is_nop), 32'(exp_nop));
        end
        if (trace_valid !== exp_valid) begin
            report_mismatch("trace_valid", 32'(trace_valid), 32'(exp_valid));
        end
        if (done !== (m_state == core_trace_pkg::DONE)) begin
            report_mismatch("done", 32'(done), 32'(m_state == core_trace_pkg::DONE));
        end
        if (counts.retired !== m_counts.retired) begin
            report_mismatch("counts.retired", 32'(counts.retired), 32'(m_counts.retired));
        end
        if (counts.branches !== m_counts.branches) begin
            report_mismatch("counts.branches", 32'(counts.branches), 32'(m_counts.branches));
        end
        if (counts.taken !== m_counts.taken) begin
            report_mismatch("counts.taken", 32'(counts.taken), 32'(m_counts.taken));
        end
        if (counts.loads !== m_counts.loads) begin
            report_mismatch("counts.loads", 32'(counts.loads), 32'(m_counts.loads));
        end
        if (counts.stores !== m_counts.stores) begin
            report_mismatch("counts.stores", 32'(counts.stores), 32'(m_counts.stores));
        end
    endtask

    initial begin
        errors = 0;
        rng = 32'h76b3;
        pc_next = 32'h0000_1000;
        // R, I, LOAD, JALR, SYSTEM, STORE, BRANCH, JAL, LUI, AUIPC
        opc_table[0] = 7'b011_0011;
        opc_table[1] = 7'b001_0011;
        opc_table[2] = 7'b000_0011;
        opc_table[3] = 7'b110_0111;
        opc_table[4] = 7'b111_0011;
        opc_table[5] = 7'b010_0011;
        opc_table[6] = 7'b110_0011;
        opc_table[7] = 7'b110_1111;
        opc_table[8] = 7'b011_0111;
        opc_table[9] = 7'b001_0111;
        clk = 1'b0;
        rst = 1'b1;
        exe = '0;
        stall = 1'b0;
        retired = 1'b0;
        start = 1'b0;
        window_len = '0;
        m_mem = EMPTY_SLOT;
        m_wbk = EMPTY_SLOT;
        m_state = core_trace_pkg::IDLE;
        m_counts = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            step_model();
            #1;
            drive_inputs(cyc);
            // outputs settle well before the next edge
            #3;
            check_outputs();
        end
        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((NUM_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: the test loop did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== inst_classifier.sv ====
`timescale 1ns/1ps

module inst_classifier (
    input core_trace_pkg::inst_width_t inst,
    output core_trace_pkg::inst_fmt_e fmt,
    output logic is_nop
);

    core_trace_pkg::opc7_t opc;

    assign opc = inst[core_trace_pkg::OPC7_WIDTH-1:0];

    // format from the opcode alone
    always_comb begin
        unique case (opc)
            core_trace_pkg::OPC7_R_TYPE: fmt = core_trace_pkg::FMT_R;
            core_trace_pkg::OPC7_I_TYPE,
            core_trace_pkg::OPC7_LOAD,
            core_trace_pkg::OPC7_JALR,
            core_trace_pkg::OPC7_SYSTEM: fmt = core_trace_pkg::FMT_I;
            core_trace_pkg::OPC7_STORE: fmt = core_trace_pkg::FMT_S;
            core_trace_pkg::OPC7_BRANCH: fmt = core_trace_pkg::FMT_B;
            core_trace_pkg::OPC7_JAL: fmt = core_trace_pkg::FMT_J;
            core_trace_pkg::OPC7_LUI,
            core_trace_pkg::OPC7_AUIPC: fmt = core_trace_pkg::FMT_U;
            // flush word (all zero) lands here too
            default: fmt = core_trace_pkg::FMT_NONE;
        endcase
    end

    // only the canonical encoding counts as a nop
    assign is_nop = (inst == core_trace_pkg::NOP_INST);

endmodule

// ==== stage_tracker.sv ====
`timescale 1ns/1ps

module stage_tracker (
    input logic clk,
    input logic rst,
    input core_trace_pkg::exe_req_t exe,
    input logic stall,
    output core_trace_pkg::stage_rec_t wbk_rec
);

    // empty slot with all fields zero and no memory access
    localparam core_trace_pkg::stage_rec_t BUBBLE = '{
        inst: '0,
        pc: '0,
        branch_inst: 1'b0,
        branch_taken: 1'b0,
        dmem_addr: '0,
        dmem_size: core_trace_pkg::DMEM_SIZE_NA
    };

    core_trace_pkg::stage_rec_t exe_rec;
    core_trace_pkg::stage_rec_t mem_rec;
    logic exe_flush;
    logic mem_flush;

    // execute-stage record from the raw request
    always_comb begin
        exe_rec.inst = exe.inst;
        exe_rec.pc = exe.pc;
        exe_rec.branch_inst = exe.branch_inst;
        // taken only means something for a branch
        exe_rec.branch_taken = exe.branch_taken && exe.branch_inst;
        if (exe.dmem_valid) begin
            exe_rec.dmem_addr = exe.dmem_addr;
            exe_rec.dmem_size = {1'b0, exe.dmem_store, exe.dmem_width};
        end else begin
            exe_rec.dmem_addr = '0;
            exe_rec.dmem_size = core_trace_pkg::DMEM_SIZE_NA;
        end
    end

    // all-zero word marks a flushed slot
    assign exe_flush = (exe.inst == '0);
    assign mem_flush = (mem_rec.inst == '0);

    // execute to memory, held while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_rec <= BUBBLE;
        end else if (!stall) begin
            if (exe_flush) begin
                mem_rec <= BUBBLE;
            end else begin
                mem_rec <= exe_rec;
            end
        end
    end

    // memory to writeback
    // a stall pushes a bubble into writeback instead of holding
    always_ff @(posedge clk) begin
        if (rst || stall || mem_flush) begin
            wbk_rec <= BUBBLE;
        end else begin
            wbk_rec <= mem_rec;
        end
    end

endmodule

// ==== trace_counters.sv ====
`timescale 1ns/1ps

module trace_counters (
    input logic clk,
    input logic rst,
    input logic clear,
    input logic count_en,
    input core_trace_pkg::retire_rec_t rec,
    output core_trace_pkg::counts_t counts
);

    logic is_access;
    logic is_load;
    logic is_store;

    // add one unless already at the top
    function automatic core_trace_pkg::count_t sat_inc(
        input core_trace_pkg::count_t value,
        input logic hit
    );
        if (hit && (value != core_trace_pkg::COUNT_MAX)) begin
            return value + core_trace_pkg::count_t'(1);
        end
        return value;
    endfunction

    // no-access code has the store bit clear, so exclude it first
    assign is_access = (rec.stage.dmem_size != core_trace_pkg::DMEM_SIZE_NA);
    assign is_store = is_access && rec.stage.dmem_size[core_trace_pkg::SIZE_STORE_BIT];
    assign is_load = is_access && !rec.stage.dmem_size[core_trace_pkg::SIZE_STORE_BIT];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            counts <= '0;
        end else if (count_en) begin
            counts.retired <= sat_inc(counts.retired, 1'b1);
            counts.branches <= sat_inc(counts.branches, rec.stage.branch_inst);
            counts.taken <= sat_inc(counts.taken, rec.stage.branch_taken);
            counts.loads <= sat_inc(counts.loads, is_load);
            counts.stores <= sat_inc(counts.stores, is_store);
        end
    end

endmodule
